//--- verilog/dispatch_pkg.sv
package dispatch_pkg;

    // Dual issue, slot 0 is always the older instruction
    localparam int ISSUE_WIDTH = 2;
    localparam int NUM_GPR = 32;

    typedef logic [4:0] reg_addr_t;
    typedef logic [31:0] data_t;
    typedef logic [7:0] alu_op_t;

    // One instruction from decode
    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        reg_addr_t [1:0] src_addr;
        logic [1:0] src_re;
        reg_addr_t dest;
        logic dest_we;
        logic use_imm;
        data_t imm;
        alu_op_t alu_op;
        logic is_mem;
        logic is_priv;
        logic has_excp;
    } decoded_instr_t;

    // Result forwarded from a later stage
    // wreg without data_valid means the value is still being computed
    typedef struct packed {
        logic wreg;
        logic data_valid;
        reg_addr_t wreg_addr;
        data_t wreg_data;
    } fwd_bus_t;

    // Issued instruction toward EX
    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        alu_op_t alu_op;
        reg_addr_t dest;
        logic dest_we;
        data_t operand1;
        data_t operand2;
    } dispatched_instr_t;

endpackage

//--- verilog/gpr_file.sv
`timescale 1ns/10ps

module gpr_file (
    input logic clk,
    input logic rst_n,

    // Read ports, index is 2 * slot + source
    input dispatch_pkg::reg_addr_t [2*dispatch_pkg::ISSUE_WIDTH-1:0] rd_addr_i,
    output dispatch_pkg::data_t [2*dispatch_pkg::ISSUE_WIDTH-1:0] rd_data_o,

    // Write ports from WB
    input dispatch_pkg::fwd_bus_t [dispatch_pkg::ISSUE_WIDTH-1:0] wb_fwd_i
);

    dispatch_pkg::data_t regs [dispatch_pkg::NUM_GPR];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < dispatch_pkg::NUM_GPR; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Slot 1 comes last so it wins on the same register
            for (int i = 0; i < dispatch_pkg::ISSUE_WIDTH; i++) begin
                if (wb_fwd_i[i].wreg && wb_fwd_i[i].data_valid && wb_fwd_i[i].wreg_addr != '0) begin
                    regs[wb_fwd_i[i].wreg_addr] <= wb_fwd_i[i].wreg_data;
                end
            end
        end
    end

    // Combinational read, r0 stays zero since it is never written
    always_comb begin
        for (int p = 0; p < 2 * dispatch_pkg::ISSUE_WIDTH; p++) begin
            rd_data_o[p] = regs[rd_addr_i[p]];
        end
    end

endmodule

//--- verilog/reg_scoreboard.sv
`timescale 1ns/10ps

module reg_scoreboard (
    input logic clk,
    input logic rst_n,
    input logic flush_i,

    // Forwarded results from the later stages
    input dispatch_pkg::fwd_bus_t [dispatch_pkg::ISSUE_WIDTH-1:0] ex_fwd_i,
    input dispatch_pkg::fwd_bus_t [dispatch_pkg::ISSUE_WIDTH-1:0] mem1_fwd_i,
    input dispatch_pkg::fwd_bus_t [dispatch_pkg::ISSUE_WIDTH-1:0] mem2_fwd_i,
    input dispatch_pkg::fwd_bus_t [dispatch_pkg::ISSUE_WIDTH-1:0] wb_fwd_i,

    // Destinations issued this cycle, already qualified by stall
    input logic [dispatch_pkg::ISSUE_WIDTH-1:0] issue_we_i,
    input dispatch_pkg::reg_addr_t [dispatch_pkg::ISSUE_WIDTH-1:0] issue_dest_i,

    output logic [dispatch_pkg::NUM_GPR-1:0] reg_avail_o
);

    localparam int NUM_STAGES = 4;

    // Index 0 is WB, index 3 is EX, so the loop order matches stage age
    dispatch_pkg::fwd_bus_t [NUM_STAGES-1:0][dispatch_pkg::ISSUE_WIDTH-1:0] upd;
    logic [dispatch_pkg::NUM_GPR-1:0] avail_nxt;

    assign upd = {ex_fwd_i, mem1_fwd_i, mem2_fwd_i, wb_fwd_i};

    always_comb begin
        avail_nxt = reg_avail_o;
        // Younger stages override older ones
        for (int s = 0; s < NUM_STAGES; s++) begin
            for (int i = 0; i < dispatch_pkg::ISSUE_WIDTH; i++) begin
                if (upd[s][i].wreg) begin
                    avail_nxt[upd[s][i].wreg_addr] = upd[s][i].data_valid;
                end
            end
        end
        // Newly issued writers win over everything
        for (int i = 0; i < dispatch_pkg::ISSUE_WIDTH; i++) begin
            if (issue_we_i[i]) begin
                avail_nxt[issue_dest_i[i]] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_avail_o <= '1;
        end else if (flush_i) begin
            reg_avail_o <= '1;
        end else begin
            reg_avail_o <= avail_nxt;
        end
    end

endmodule

//--- verilog/operand_bypass.sv
`timescale 1ns/10ps

module operand_bypass (
    input dispatch_pkg::decoded_instr_t [dispatch_pkg::ISSUE_WIDTH-1:0] id_i,

    // Register file read data, index is 2 * slot + source
    input dispatch_pkg::data_t [2*dispatch_pkg::ISSUE_WIDTH-1:0] rd_data_i,

    input dispatch_pkg::fwd_bus_t [dispatch_pkg::ISSUE_WIDTH-1:0] ex_fwd_i,
    input dispatch_pkg::fwd_bus_t [dispatch_pkg::ISSUE_WIDTH-1:0] mem1_fwd_i,
    input dispatch_pkg::fwd_bus_t [dispatch_pkg::ISSUE_WIDTH-1:0] mem2_fwd_i,
    input dispatch_pkg::fwd_bus_t [dispatch_pkg::ISSUE_WIDTH-1:0] wb_fwd_i,

    output dispatch_pkg::data_t [2*dispatch_pkg::ISSUE_WIDTH-1:0] operand_o
);

    localparam int NUM_STAGES = 4;

    // Lowest priority first, WB at 0 and EX at 3
    dispatch_pkg::fwd_bus_t [NUM_STAGES-1:0][dispatch_pkg::ISSUE_WIDTH-1:0] fwd;

    assign fwd = {ex_fwd_i, mem1_fwd_i, mem2_fwd_i, wb_fwd_i};

    always_comb begin
        dispatch_pkg::reg_addr_t src;
        for (int slot = 0; slot < dispatch_pkg::ISSUE_WIDTH; slot++) begin
            for (int op = 0; op < 2; op++) begin
                src = id_i[slot].src_addr[op];
                operand_o[2*slot+op] = rd_data_i[2*slot+op];

                // Each later match overrides, so EX slot 1 has the last word
                for (int s = 0; s < NUM_STAGES; s++) begin
                    for (int i = 0; i < dispatch_pkg::ISSUE_WIDTH; i++) begin
                        if (fwd[s][i].wreg && fwd[s][i].wreg_addr == src) begin
                            operand_o[2*slot+op] = fwd[s][i].wreg_data;
                        end
                    end
                end

                // r0 reads zero even if someone forwards to it
                if (src == '0) begin
                    operand_o[2*slot+op] = '0;
                end
            end
        end
    end

endmodule

//--- verilog/issue_ctrl.sv
`timescale 1ns/10ps

module issue_ctrl (
    input logic clk,
    input logic rst_n,
    input logic stall_i,
    input logic flush_i,

    input dispatch_pkg::decoded_instr_t [dispatch_pkg::ISSUE_WIDTH-1:0] id_i,
    input logic [dispatch_pkg::NUM_GPR-1:0] reg_avail_i,
    input dispatch_pkg::data_t [2*dispatch_pkg::ISSUE_WIDTH-1:0] operand_i,

    // Back to the instruction buffer, same cycle as id_i
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0] ib_accept_o,

    // To the scoreboard
    output logic [dispatch_pkg::ISSUE_WIDTH-1:0] issue_we_o,
    output dispatch_pkg::reg_addr_t [dispatch_pkg::ISSUE_WIDTH-1:0] issue_dest_o,

    output dispatch_pkg::dispatched_instr_t [dispatch_pkg::ISSUE_WIDTH-1:0] exe_o
);

    logic [dispatch_pkg::ISSUE_WIDTH-1:0] src_ready;
    logic [dispatch_pkg::ISSUE_WIDTH-1:0] issue;
    logic single_issue;
    logic raw_dep;
    dispatch_pkg::dispatched_instr_t [dispatch_pkg::ISSUE_WIDTH-1:0] exe_nxt;

    // Only enabled sources need a ready register
    always_comb begin
        for (int i = 0; i < dispatch_pkg::ISSUE_WIDTH; i++) begin
            src_ready[i] = (!id_i[i].src_re[0] || reg_avail_i[id_i[i].src_addr[0]])
                        && (!id_i[i].src_re[1] || reg_avail_i[id_i[i].src_addr[1]]);
        end
    end

    // Memory, privileged and excepting instructions go alone
    assign single_issue = id_i[0].is_mem || id_i[0].is_priv || id_i[0].has_excp
                       || id_i[1].is_mem || id_i[1].is_priv || id_i[1].has_excp;

    // Slot 1 reading what slot 0 writes
    always_comb begin
        raw_dep = 1'b0;
        for (int j = 0; j < 2; j++) begin
            if (id_i[1].src_re[j] && id_i[0].dest_we && id_i[1].src_addr[j] == id_i[0].dest) begin
                raw_dep = 1'b1;
            end
        end
    end

    assign issue[0] = id_i[0].valid && src_ready[0];
    assign issue[1] = issue[0] && id_i[1].valid && src_ready[1] && !single_issue && !raw_dep;

    always_comb begin
        if (stall_i) begin
            ib_accept_o = '0;
        end else if (issue == 2'b01 && !id_i[1].valid) begin
            // Let the buffer drop the empty slot together with slot 0
            ib_accept_o = 2'b11;
        end else begin
            ib_accept_o = issue;
        end
    end

    always_comb begin
        for (int i = 0; i < dispatch_pkg::ISSUE_WIDTH; i++) begin
            issue_we_o[i] = issue[i] && id_i[i].dest_we && !stall_i;
            issue_dest_o[i] = id_i[i].dest;

            exe_nxt[i] = '0;
            if (issue[i]) begin
                exe_nxt[i].valid = 1'b1;
                exe_nxt[i].pc = id_i[i].pc;
                exe_nxt[i].alu_op = id_i[i].alu_op;
                exe_nxt[i].dest = id_i[i].dest;
                exe_nxt[i].dest_we = id_i[i].dest_we;
                exe_nxt[i].operand1 = operand_i[2*i];
                exe_nxt[i].operand2 = id_i[i].use_imm ? id_i[i].imm : operand_i[2*i+1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_o <= '0;
        end else if (flush_i) begin
            exe_o <= '0;
        end else if (!stall_i) begin
            exe_o <= exe_nxt;
        end
    end

endmodule

//--- verilog/dispatch_stage.sv
`timescale 1ns/10ps

module dispatch_stage (
    input logic clk,
    input logic rst_n,

    // From decode, slot 0 is older
    input dispatch_pkg::decoded_instr_t [dispatch_pkg::ISSUE_WIDTH-1:0] id_i,

    input logic stall_i,
    input logic flush_i,

    // Forwarding from EX, MEM1, MEM2 and WB
    input dispatch_pkg::fwd_bus_t [dispatch_pkg::ISSUE_WIDTH-1:0] ex_fwd_i,
    input dispatch_pkg::fwd_bus_t [dispatch_pkg::ISSUE_WIDTH-1:0] mem1_fwd_i,
    input dispatch_pkg::fwd_bus_t [dispatch_pkg::ISSUE_WIDTH-1:0] mem2_fwd_i,
    input dispatch_pkg::fwd_bus_t [dispatch_pkg::ISSUE_WIDTH-1:0] wb_fwd_i,

    output logic [dispatch_pkg::ISSUE_WIDTH-1:0] ib_accept_o,
    output dispatch_pkg::dispatched_instr_t [dispatch_pkg::ISSUE_WIDTH-1:0] exe_o
);

    dispatch_pkg::reg_addr_t [2*dispatch_pkg::ISSUE_WIDTH-1:0] rd_addr;
    dispatch_pkg::data_t [2*dispatch_pkg::ISSUE_WIDTH-1:0] rd_data;
    dispatch_pkg::data_t [2*dispatch_pkg::ISSUE_WIDTH-1:0] operand;
    logic [dispatch_pkg::NUM_GPR-1:0] reg_avail;
    logic [dispatch_pkg::ISSUE_WIDTH-1:0] issue_we;
    dispatch_pkg::reg_addr_t [dispatch_pkg::ISSUE_WIDTH-1:0] issue_dest;

    // Read port 2 * slot + source
    assign rd_addr = {id_i[1].src_addr, id_i[0].src_addr};

    gpr_file u_gpr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .wb_fwd_i  (wb_fwd_i)
    );

    reg_scoreboard u_reg_scoreboard (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .ex_fwd_i     (ex_fwd_i),
        .mem1_fwd_i   (mem1_fwd_i),
        .mem2_fwd_i   (mem2_fwd_i),
        .wb_fwd_i     (wb_fwd_i),
        .issue_we_i   (issue_we),
        .issue_dest_i (issue_dest),
        .reg_avail_o  (reg_avail)
    );

    operand_bypass u_operand_bypass (
        .id_i       (id_i),
        .rd_data_i  (rd_data),
        .ex_fwd_i   (ex_fwd_i),
        .mem1_fwd_i (mem1_fwd_i),
        .mem2_fwd_i (mem2_fwd_i),
        .wb_fwd_i   (wb_fwd_i),
        .operand_o  (operand)
    );

    issue_ctrl u_issue_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .id_i         (id_i),
        .reg_avail_i  (reg_avail),
        .operand_i    (operand),
        .ib_accept_o  (ib_accept_o),
        .issue_we_o   (issue_we),
        .issue_dest_o (issue_dest),
        .exe_o        (exe_o)
    );

endmodule

//--- dv/dispatch_sva.sv
`timescale 1ns/10ps

module dispatch_sva (
    input logic clk,
    input logic rst_n,
    input logic stall_i,
    input logic flush_i,
    input logic [dispatch_pkg::ISSUE_WIDTH-1:0] ib_accept_i,
    input dispatch_pkg::dispatched_instr_t [dispatch_pkg::ISSUE_WIDTH-1:0] exe_i,
    input logic [dispatch_pkg::NUM_GPR-1:0] reg_avail_i,

    // Expected values from the testbench model
    input logic [dispatch_pkg::ISSUE_WIDTH-1:0] exp_accept_i,
    input dispatch_pkg::dispatched_instr_t [dispatch_pkg::ISSUE_WIDTH-1:0] exp_exe_i,
    input logic [dispatch_pkg::NUM_GPR-1:0] exp_avail_i
);

    int fail_count = 0;

    accept_rule: assert property (@(posedge clk) disable iff (!rst_n)
        ib_accept_i == exp_accept_i)
        else begin
            fail_count++;
            $error("MISMATCH ib_accept_o got %h expected %h",
                   $sampled(ib_accept_i), $sampled(exp_accept_i));
        end

    avail_rule: assert property (@(posedge clk) disable iff (!rst_n)
        reg_avail_i == exp_avail_i)
        else begin
            fail_count++;
            $error("MISMATCH reg_avail got %h expected %h",
                   $sampled(reg_avail_i), $sampled(exp_avail_i));
        end

    // Covers operands, immediates and r0 in one compare
    exe_rule: assert property (@(posedge clk) disable iff (!rst_n)
        exe_i == exp_exe_i)
        else begin
            fail_count++;
            $error("MISMATCH exe_o got %h expected %h",
                   $sampled(exe_i), $sampled(exp_exe_i));
        end

    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (stall_i && !flush_i) |=> exe_i == $past(exe_i))
        else begin
            fail_count++;
            $error("MISMATCH exe_o during stall got %h expected %h",
                   $sampled(exe_i), $past(exe_i));
        end

    flush_clear: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> (!exe_i[0].valid && !exe_i[1].valid))
        else begin
            fail_count++;
            $error("MISMATCH exe_o valid after flush got %h expected 0",
                   {$sampled(exe_i[1].valid), $sampled(exe_i[0].valid)});
        end

endmodule

//--- dv/dispatch_tb.sv
`timescale 1ns/10ps

module dispatch_tb;

    localparam int RUN_CYCLES = 3000;
    localparam int WAIT_LIMIT = 200;

    logic clk;
    logic rst_n;
    logic stall;
    logic flush;
    dispatch_pkg::decoded_instr_t [1:0] id;
    dispatch_pkg::fwd_bus_t [1:0] ex_fwd;
    dispatch_pkg::fwd_bus_t [1:0] mem1_fwd;
    dispatch_pkg::fwd_bus_t [1:0] mem2_fwd;
    dispatch_pkg::fwd_bus_t [1:0] wb_fwd;
    logic [1:0] ib_accept;
    dispatch_pkg::dispatched_instr_t [1:0] exe;

    // Reference model state
    dispatch_pkg::data_t regs_m [32];
    logic [31:0] avail_m;
    logic [1:0] exp_issue;
    logic [1:0] exp_accept;
    dispatch_pkg::dispatched_instr_t [1:0] exp_exe_nxt;
    dispatch_pkg::dispatched_instr_t [1:0] exp_exe;
    logic [31:0] lfsr;

    dispatch_stage dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_i       (id),
        .stall_i    (stall),
        .flush_i    (flush),
        .ex_fwd_i   (ex_fwd),
        .mem1_fwd_i (mem1_fwd),
        .mem2_fwd_i (mem2_fwd),
        .wb_fwd_i   (wb_fwd),
        .ib_accept_o(ib_accept),
        .exe_o      (exe)
    );

    bind dispatch_stage dispatch_sva u_sva (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .ib_accept_i  (ib_accept_o),
        .exe_i        (exe_o),
        .reg_avail_i  (reg_avail),
        .exp_accept_i (dispatch_tb.exp_accept),
        .exp_exe_i    (dispatch_tb.exp_exe),
        .exp_avail_i  (dispatch_tb.avail_m)
    );

    always #10 clk = ~clk;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        logic b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], b};
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic dispatch_pkg::decoded_instr_t rand_instr();
        dispatch_pkg::decoded_instr_t ins;
        ins.valid = take_bits(3) != 0;
        ins.pc = take_bits(32);
        // Only r0..r7, so hazards come often
        ins.src_addr[0] = 5'(take_bits(3));
        ins.src_addr[1] = 5'(take_bits(3));
        ins.src_re = 2'(take_bits(2));
        ins.dest = 5'(take_bits(3));
        ins.dest_we = 1'(take_bits(1));
        ins.use_imm = 1'(take_bits(1));
        ins.imm = take_bits(32);
        ins.alu_op = 8'(take_bits(8));
        ins.is_mem = take_bits(4) == 0;
        ins.is_priv = take_bits(5) == 0;
        ins.has_excp = take_bits(5) == 0;
        return ins;
    endfunction

    function automatic dispatch_pkg::fwd_bus_t rand_fwd();
        dispatch_pkg::fwd_bus_t f;
        f.wreg = take_bits(2) == 0;
        f.data_valid = 1'(take_bits(1));
        f.wreg_addr = 5'(take_bits(3));
        f.wreg_data = take_bits(32);
        return f;
    endfunction

    // Register file value with later stages and slot 1 taking over
    function automatic dispatch_pkg::data_t predict_operand(dispatch_pkg::reg_addr_t a);
        dispatch_pkg::data_t v;
        dispatch_pkg::fwd_bus_t [3:0][1:0] by_age;
        by_age = {ex_fwd, mem1_fwd, mem2_fwd, wb_fwd};
        v = regs_m[a];
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 2; k++) begin
                if (by_age[s][k].wreg && by_age[s][k].wreg_addr == a) begin
                    v = by_age[s][k].wreg_data;
                end
            end
        end
        return (a == '0) ? '0 : v;
    endfunction

    function automatic logic sources_free(dispatch_pkg::decoded_instr_t ins);
        return (!ins.src_re[0] || avail_m[ins.src_addr[0]])
            && (!ins.src_re[1] || avail_m[ins.src_addr[1]]);
    endfunction

    function automatic logic goes_alone(dispatch_pkg::decoded_instr_t ins);
        return ins.is_mem || ins.is_priv || ins.has_excp;
    endfunction

    function automatic logic reads_reg(dispatch_pkg::decoded_instr_t ins,
                                       dispatch_pkg::reg_addr_t r);
        return (ins.src_re[0] && ins.src_addr[0] == r) || (ins.src_re[1] && ins.src_addr[1] == r);
    endfunction

    always_comb begin
        exp_issue[0] = id[0].valid && sources_free(id[0]);
        exp_issue[1] = exp_issue[0] && id[1].valid && sources_free(id[1])
                    && !goes_alone(id[0]) && !goes_alone(id[1])
                    && !(id[0].dest_we && reads_reg(id[1], id[0].dest));
        if (stall) begin
            exp_accept = 2'b00;
        end else if (exp_issue == 2'b01 && !id[1].valid) begin
            exp_accept = 2'b11;
        end else begin
            exp_accept = exp_issue;
        end
        for (int k = 0; k < 2; k++) begin
            exp_exe_nxt[k] = '0;
            if (exp_issue[k]) begin
                exp_exe_nxt[k] = '{valid: 1'b1, pc: id[k].pc, alu_op: id[k].alu_op,
                    dest: id[k].dest, dest_we: id[k].dest_we,
                    operand1: predict_operand(id[k].src_addr[0]),
                    operand2: id[k].use_imm ? id[k].imm : predict_operand(id[k].src_addr[1])};
            end
        end
    end

    // Shadow register file, scoreboard and EX register
    always @(posedge clk) begin
        logic [31:0] nxt;
        dispatch_pkg::fwd_bus_t [3:0][1:0] by_age;
        by_age = {ex_fwd, mem1_fwd, mem2_fwd, wb_fwd};
        if (!rst_n) begin
            for (int r = 0; r < 32; r++) begin
                regs_m[r] <= '0;
            end
            avail_m <= '1;
            exp_exe <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (wb_fwd[k].wreg && wb_fwd[k].data_valid && wb_fwd[k].wreg_addr != '0) begin
                    regs_m[wb_fwd[k].wreg_addr] <= wb_fwd[k].wreg_data;
                end
            end
            nxt = avail_m;
            for (int s = 0; s < 4; s++) begin
                for (int k = 0; k < 2; k++) begin
                    if (by_age[s][k].wreg) begin
                        nxt[by_age[s][k].wreg_addr] = by_age[s][k].data_valid;
                    end
                end
            end
            for (int k = 0; k < 2; k++) begin
                if (exp_issue[k] && id[k].dest_we && !stall) begin
                    nxt[id[k].dest] = 1'b0;
                end
            end
            avail_m <= flush ? '1 : nxt;
            if (flush) begin
                exp_exe <= '0;
            end else if (!stall) begin
                exp_exe <= exp_exe_nxt;
            end
        end
    end

    task automatic drive_random();
        id <= {rand_instr(), rand_instr()};
        ex_fwd <= {rand_fwd(), rand_fwd()};
        mem1_fwd <= {rand_fwd(), rand_fwd()};
        mem2_fwd <= {rand_fwd(), rand_fwd()};
        wb_fwd <= {rand_fwd(), rand_fwd()};
        stall <= take_bits(4) == 0;
        flush <= take_bits(5) == 0;
    endtask

    task automatic check_errors();
        if (dut.u_sva.fail_count != 0) begin
            $display("Checks failed");
            $fatal(1, "assertion failure seen");
        end
    endtask

    initial begin
        int waited;
        clk = 1'b0;
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        id = '0;
        ex_fwd = '0;
        mem1_fwd = '0;
        mem2_fwd = '0;
        wb_fwd = '0;
        lfsr = 32'h9533_2d1b;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // First accept must show up soon after reset
        waited = 0;
        do begin
            @(posedge clk);
            drive_random();
            @(negedge clk);
            check_errors();
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Checks failed");
                $fatal(1, "no instruction was accepted after reset");
            end
        end while (ib_accept == 2'b00);

        for (int c = 0; c < RUN_CYCLES; c++) begin
            @(posedge clk);
            drive_random();
            @(negedge clk);
            check_errors();
        end

        @(posedge clk);
        @(negedge clk);
        if (dut.u_sva.fail_count != 0) begin
            $display("Checks failed");
            $fatal(1, "assertion failure seen");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

//--- dual_dispatch.f
verilog/dispatch_pkg.sv
verilog/gpr_file.sv
verilog/reg_scoreboard.sv
verilog/operand_bypass.sv
verilog/issue_ctrl.sv
verilog/dispatch_stage.sv
dv/dispatch_sva.sv
dv/dispatch_tb.sv

//--- Makefile
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP       ?= dispatch_tb
FILELIST  ?= dual_dispatch.f
RUN_ARGS  ?= +verilator+error+limit+100

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
